/* tb.f */
verilog/vrc6_pkg.sv
verilog/vrc6_regs.sv
verilog/vrc6_map.sv
verilog/vrc6_irq.sv
verilog/vrc6_top.sv
test/tb_vrc6_assert.sv
test/tb_vrc6.sv

/* Makefile */
TOP = tb_vrc6

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f tb.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f tb.f --Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "ERRORS FOUND" sim.log || ! grep -q "NO ERRORS" sim.log; then \
		echo "simulation failed"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf obj_dir sim.log

/* test/tb_vrc6.sv */
`timescale 1ns/100ps

module tb_vrc6;

	// reset, defaults, two bank runs, cycle irq, scanline irq, save-state
	localparam int TEST_CYCLES = 20 + 25 + 2450 + 1050 + 2410 + 120;

	logic                clk;
	logic                map_rst;
	logic [7:0]          map_idx;
	vrc6_pkg::cpu_bus_t  cpu;
	logic                cpu_tick;
	vrc6_pkg::ppu_addr_t ppu_addr;
	logic                ppu_oe;
	vrc6_pkg::ss_bus_t   ss;
	vrc6_pkg::map_out_t  map_out;
	logic                irq;
	logic [7:0]          ss_rdat;

	integer      seed;
	logic [31:0] rnd;
	int          tests;
	int          checks;
	int          errors;
	int          err0;

	// reference model
	logic [7:0] m_prg0;
	logic [7:0] m_prg1;
	logic [7:0] m_chr [8];
	logic [1:0] m_mir;
	logic [7:0] m_latch;
	logic [7:0] m_count;
	logic [2:0] m_ctrl; // {m, e, a}
	int         m_presc;
	logic       m_irq;

	vrc6_top u_dut (.*);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial
	begin
		#(TEST_CYCLES * 20);
		$display("watchdog timeout after %0d cycles, simulation stopped", 2 * TEST_CYCLES);
		$display("ERRORS FOUND");
		$finish;
	end

	task automatic model_irq_write(input logic [1:0] sel, input logic [7:0] d);
		if (sel != vrc6_pkg::IRQ_SEL_LATCH)
			m_irq = 1'b0; // control and ack both clear the line
		if (sel == vrc6_pkg::IRQ_SEL_LATCH)
			m_latch = d;
		else if (sel == vrc6_pkg::IRQ_SEL_ACK)
			m_ctrl[vrc6_pkg::CTRL_E] = m_ctrl[vrc6_pkg::CTRL_A];
		else
		begin
			m_ctrl  = d[2:0];
			m_count = d[vrc6_pkg::CTRL_E] ? m_latch : m_count;
			m_presc = d[vrc6_pkg::CTRL_E] ? int'(vrc6_pkg::PRESCALE_RELOAD) : m_presc;
		end
	endtask

	task automatic model_tick();
		logic step;
		step = m_ctrl[vrc6_pkg::CTRL_E] & m_ctrl[vrc6_pkg::CTRL_M]; // cycle mode
		if (m_ctrl[vrc6_pkg::CTRL_E] && !m_ctrl[vrc6_pkg::CTRL_M])
		begin
			m_presc = m_presc - int'(vrc6_pkg::PRESCALE_STEP);
			step    = (m_presc <= 0);
			if (step)
				m_presc = m_presc + int'(vrc6_pkg::PRESCALE_RELOAD);
		end
		if (step)
		begin
			m_irq   = m_irq | (m_count == 8'hFF);
			m_count = (m_count == 8'hFF) ? m_latch : m_count + 8'd1;
		end
	endtask

	task automatic model_bus_write(input logic [15:0] a, input logic [7:0] d);
		logic [1:0] lo;
		lo = (a[3:2] != 2'd0) ? a[3:2] : a[1:0];
		if (map_idx == vrc6_pkg::MAP_VRC6B)
			lo = {lo[0], lo[1]}; // mapper 26 swaps the low lines
		case (a[15:12])
			4'h8: m_prg0 = d;
			4'hB: m_mir = (lo == 2'd3) ? d[3:2] : m_mir;
			4'hC: m_prg1 = d;
			4'hD: m_chr[{1'b0, lo}] = d;
			4'hE: m_chr[{1'b1, lo}] = d;
			4'hF:
				if (lo != 2'd3)
					model_irq_write(lo, d);
			default: ;
		endcase
	endtask

	task automatic check_map(input string name, input vrc6_pkg::map_out_t exp,
		input vrc6_pkg::map_out_t act);
		checks++;
		if (exp !== act)
		begin
			$display("ERR %0s: expected %h, actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_irq(input string name, input logic exp, input logic act);
		checks++;
		if (exp !== act)
		begin
			$display("ERR %0s: expected irq %b, actual %b", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_ss(input string name, input logic [7:0] exp, input logic [7:0] act);
		checks++;
		if (exp !== act)
		begin
			$display("ERR %0s: expected %h, actual %h at %0d", name, exp, act, ss.addr);
			errors++;
		end
	endtask

	// drives a random cpu and ppu address and checks the combinational map
	task automatic probe_map(input string name);
		vrc6_pkg::map_out_t e;
		@(negedge clk);
		rnd      = $random(seed);
		cpu.addr = rnd[15:0];
		cpu.we   = ~rnd[15] & rnd[16]; // writes only below the register space
		ppu_addr = rnd[30:17];
		ppu_oe   = rnd[31];
		#1;
		e.prg_addr  = {(rnd[15:13] == 3'b111) ? 8'hFF : (rnd[15:13] == 3'b110) ? m_prg1 :
			{m_prg0[6:0], rnd[13]}, rnd[12:0]};
		e.chr_addr  = {m_chr[ppu_addr[12:10]], ppu_addr[9:0]};
		e.srm_addr  = rnd[12:0];
		e.ciram_a10 = m_mir[1] ? m_mir[0] : (m_mir[0] ? ppu_addr[11] : ppu_addr[10]);
		e.ciram_ce  = ~ppu_addr[13];
		e.rom_ce    = rnd[15];
		e.ram_ce    = (rnd[15:0] >= 16'h6000) && (rnd[15:0] < 16'h8000);
		e.ram_we    = e.ram_ce & cpu.we;
		e.prg_oe    = ~cpu.we;
		e.chr_oe    = ~ppu_oe;
		check_map(name, e, map_out);
		cpu.we = 1'b0;
	endtask

	task automatic bus_write(input logic [15:0] a, input logic [7:0] d, input logic track);
		@(negedge clk);
		cpu.addr = a;
		cpu.data = d;
		cpu.we   = 1'b1;
		@(negedge clk);
		cpu.we = 1'b0;
		if (track)
			model_bus_write(a, d);
	endtask

	task automatic do_tick(input string name);
		@(negedge clk);
		cpu_tick = 1'b1;
		@(negedge clk);
		cpu_tick = 1'b0;
		model_tick();
		check_irq(name, m_irq, irq);
	endtask

	task automatic ss_write(input logic [7:0] a, input logic [7:0] d);
		@(negedge clk);
		ss.addr = a;
		ss.wdat = d;
		ss.we   = 1'b1;
		@(negedge clk);
		ss.we = 1'b0;
		case (a)
			vrc6_pkg::SS_PRG0: m_prg0 = d;
			vrc6_pkg::SS_PRG1: m_prg1 = d;
			vrc6_pkg::SS_MIR:  m_mir = d[1:0];
			default:           m_chr[a[2:0]] = d;
		endcase
	endtask

	task automatic ss_check(input logic [7:0] a, input logic [7:0] exp);
		@(negedge clk);
		ss.addr = a;
		#1;
		check_ss("save_state", exp, ss_rdat);
	endtask

	task automatic bank_run(input string name);
		logic [3:0] nib;
		for (int i = 0; i < 200; i++)
		begin
			rnd = $random(seed);
			nib = (rnd[14:12] == 3'd7) ? 4'hD : {1'b1, rnd[14:12]}; // 8..E with D drawn twice as often
			bus_write({nib, rnd[11:0]}, rnd[23:16], 1'b1);
			for (int j = 0; j < 4; j++)
				probe_map(name);
		end
	endtask

	task automatic test_done(input string name);
		tests++;
		$display("test %0s finished, %0d failed checks", name, errors - err0);
		err0 = errors;
	endtask

	initial
	begin
		int n;
		int k;
		seed     = 42;
		tests    = 0;
		checks   = 0;
		errors   = 0;
		err0     = 0;
		map_rst  = 1'b1;
		map_idx  = vrc6_pkg::MAP_VRC6A;
		cpu      = '0;
		cpu_tick = 1'b0;
		ppu_addr = '0;
		ppu_oe   = 1'b0;
		ss       = '0;
		m_prg0   = 8'd0;
		m_prg1   = 8'd1;
		m_mir    = 2'd0;
		m_latch  = 8'd0;
		m_count  = 8'd0;
		m_ctrl   = 3'd0;
		m_presc  = int'(vrc6_pkg::PRESCALE_RELOAD);
		m_irq    = 1'b0;
		for (int i = 0; i < 8; i++)
			m_chr[i] = 8'd0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		map_rst = 1'b0;

		for (int i = 0; i < 20; i++)
			probe_map("reset_defaults");
		check_irq("reset_defaults", 1'b0, irq);
		test_done("reset_defaults");

		bank_run("banks_map24");
		test_done("banks_map24");

		@(negedge clk);
		map_idx = vrc6_pkg::MAP_VRC6B;
		bank_run("banks_map26");
		for (int m = 0; m < 4; m++)
		begin
			rnd = $random(seed);
			bus_write(16'hB003, {rnd[7:4], m[1:0], rnd[1:0]}, 1'b1); // mirroring in 3:2
			for (int j = 0; j < 6; j++)
				probe_map("banks_map26");
		end
		test_done("banks_map26");
		@(negedge clk);
		map_idx = vrc6_pkg::MAP_VRC6A;

		rnd = $random(seed);
		bus_write(16'hF000, rnd[7:0], 1'b1);
		bus_write(16'hF001, 8'h07, 1'b1); // m, e and a
		n = 256 - int'(m_latch);
		for (int pass = 0; pass < 2; pass++)
		begin
			for (int i = 0; i < n; i++)
				do_tick("irq_cycle");
			check_irq("irq_cycle", 1'b1, irq);
			bus_write(16'hF002, 8'h00, 1'b1); // ack copies a into e
			check_irq("irq_cycle", 1'b0, irq);
		end
		test_done("irq_cycle");

		rnd = $random(seed);
		bus_write(16'hF000, {5'b11111, rnd[2:0]}, 1'b1); // short run near overflow
		bus_write(16'hF001, 8'h02, 1'b1);
		k = 0;
		while (!m_irq && k < 1200)
		begin
			do_tick("irq_scanline");
			k++;
		end
		if (!m_irq)
		begin
			$display("scanline irq never fired within %0d ticks", k);
			errors++;
		end
		bus_write(16'hF001, 8'h00, 1'b1);
		check_irq("irq_scanline", 1'b0, irq);
		test_done("irq_scanline");

		@(negedge clk);
		ss.act = 1'b1;
		for (int a = 0; a < 19; a++)
		begin
			rnd = $random(seed);
			if (a < 8 || a > 15)
				ss_write(8'(a), rnd[7:0]);
		end
		for (int a = 0; a < 8; a++)
			ss_check(8'(a), m_chr[a]);
		ss_check(vrc6_pkg::SS_PRG0, m_prg0);
		ss_check(vrc6_pkg::SS_PRG1, m_prg1);
		ss_check(vrc6_pkg::SS_MIR, {6'd0, m_mir});
		for (int i = 0; i < 8; i++)
			probe_map("save_state");
		ss_check(vrc6_pkg::SS_IRQ_LATCH, m_latch);
		ss_check(vrc6_pkg::SS_IRQ_COUNT, m_count);
		ss_check(vrc6_pkg::SS_IRQ_CTRL, {5'd0, m_ctrl});
		ss_check(vrc6_pkg::SS_MAP_IDX, map_idx);
		for (int i = 0; i < 6; i++)
		begin
			rnd = $random(seed);
			ss_check({1'b1, rnd[6:0]}, 8'hFF);
			ss_check({5'd1, rnd[10:8]}, 8'hFF); // 8..15
		end
		bus_write(16'h8000, ~m_prg0, 1'b0); // all ignored while save-state is active
		bus_write(16'hC000, ~m_prg1, 1'b0);
		bus_write(16'hD000, ~m_chr[0], 1'b0);
		bus_write(16'hF000, ~m_latch, 1'b0);
		ss_check(vrc6_pkg::SS_PRG0, m_prg0);
		ss_check(vrc6_pkg::SS_PRG1, m_prg1);
		ss_check(vrc6_pkg::SS_CHR, m_chr[0]);
		ss_check(vrc6_pkg::SS_IRQ_LATCH, m_latch);
		@(negedge clk);
		ss.act = 1'b0;
		test_done("save_state");

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

/* test/tb_vrc6_assert.sv */
`timescale 1ns/100ps

module tb_vrc6_assert
(
	input logic                 clk,
	input logic                 map_rst,
	input logic                 cpu_tick,
	input vrc6_pkg::irq_wr_t    irq_wr,
	input logic                 irq,
	input vrc6_pkg::irq_state_t irq_st
);

	logic ctrl_wr;
	logic clr_wr;

	assign ctrl_wr = irq_wr.we & (irq_wr.sel == vrc6_pkg::IRQ_SEL_CTRL);
	assign clr_wr  = ctrl_wr | (irq_wr.we & (irq_wr.sel == vrc6_pkg::IRQ_SEL_ACK));

	irq_low_in_reset: assert property (@(posedge clk) map_rst |=> !irq)
		else $error("irq is high during or right after reset");

	// control and ack both drop the line one edge later
	irq_clear_on_write: assert property (@(posedge clk) (!map_rst && clr_wr) |=> !irq)
		else $error("irq still high after a control or ack write");

	count_stable: assert property (@(posedge clk)
		(!map_rst && !cpu_tick && !ctrl_wr) |=> $stable(irq_st.count))
		else $error("irq counter moved without a tick or a control write");

endmodule

bind vrc6_irq tb_vrc6_assert u_irq_assert
(
	.clk      (clk),
	.map_rst  (map_rst),
	.cpu_tick (cpu_tick),
	.irq_wr   (irq_wr),
	.irq      (irq),
	.irq_st   (irq_st)
);

/* verilog/vrc6_top.sv */
`timescale 1ns/100ps

module vrc6_top
(
	input  logic                clk,
	input  logic                map_rst,
	input  logic [7:0]          map_idx,
	input  vrc6_pkg::cpu_bus_t  cpu,
	input  logic                cpu_tick,
	input  vrc6_pkg::ppu_addr_t ppu_addr,
	input  logic                ppu_oe,
	input  vrc6_pkg::ss_bus_t   ss,
	output vrc6_pkg::map_out_t  map_out,
	output logic                irq,
	output logic [7:0]          ss_rdat
);

	vrc6_pkg::bank_regs_t regs;
	vrc6_pkg::irq_wr_t    irq_wr;
	vrc6_pkg::irq_state_t irq_st;

	// bus decode, bank registers and save-state
	vrc6_regs u_regs
	(
		.clk     (clk),
		.map_rst (map_rst),
		.map_idx (map_idx),
		.cpu     (cpu),
		.ss      (ss),
		.irq_st  (irq_st),
		.regs    (regs),
		.irq_wr  (irq_wr),
		.ss_rdat (ss_rdat)
	);

	vrc6_map u_map
	(
		.regs     (regs),
		.cpu      (cpu),
		.ppu_addr (ppu_addr),
		.ppu_oe   (ppu_oe),
		.map_out  (map_out)
	);

	vrc6_irq u_irq
	(
		.clk      (clk),
		.map_rst  (map_rst),
		.cpu_tick (cpu_tick),
		.irq_wr   (irq_wr),
		.irq      (irq),
		.irq_st   (irq_st)
	);

endmodule

/* verilog/vrc6_irq.sv */
`timescale 1ns/100ps

module vrc6_irq
(
	input  logic                 clk,
	input  logic                 map_rst,
	input  logic                 cpu_tick,
	input  vrc6_pkg::irq_wr_t    irq_wr,
	output logic                 irq,
	output vrc6_pkg::irq_state_t irq_st
);

	logic [7:0]        latch;
	logic [7:0]        count;
	logic [2:0]        ctrl;
	logic signed [9:0] presc;
	logic signed [9:0] presc_dec;
	logic              presc_wrap;
	logic              latch_wr;
	logic              ctrl_wr;
	logic              ack_wr;
	logic              run;
	logic              cnt_clk;

	assign latch_wr = irq_wr.we & (irq_wr.sel == vrc6_pkg::IRQ_SEL_LATCH);
	assign ctrl_wr  = irq_wr.we & (irq_wr.sel == vrc6_pkg::IRQ_SEL_CTRL);
	assign ack_wr   = irq_wr.we & (irq_wr.sel == vrc6_pkg::IRQ_SEL_ACK);

	assign presc_dec  = presc - vrc6_pkg::PRESCALE_STEP;
	assign presc_wrap = (presc_dec <= 10'sd0);

	// a control or ack write holds off the tick for that cycle
	assign run     = ctrl[vrc6_pkg::CTRL_E] & cpu_tick & ~ctrl_wr & ~ack_wr;
	assign cnt_clk = run & (ctrl[vrc6_pkg::CTRL_M] | presc_wrap);

	always_ff @(posedge clk)
	begin
		if (map_rst)
		begin
			latch <= 8'd0;
			count <= 8'd0;
			ctrl  <= 3'd0;
			presc <= vrc6_pkg::PRESCALE_RELOAD;
			irq   <= 1'b0;
		end
		else if (ctrl_wr)
		begin
			ctrl <= irq_wr.data[2:0];
			irq  <= 1'b0;
			if (irq_wr.data[vrc6_pkg::CTRL_E])
			begin
				count <= latch;
				presc <= vrc6_pkg::PRESCALE_RELOAD;
			end
		end
		else
		begin
			if (latch_wr)
				latch <= irq_wr.data;

			if (ack_wr)
			begin
				irq <= 1'b0;
				ctrl[vrc6_pkg::CTRL_E] <= ctrl[vrc6_pkg::CTRL_A];
			end

			// scanline mode steps 341 dots per line by 3
			if (run && !ctrl[vrc6_pkg::CTRL_M])
			begin
				if (presc_wrap)
					presc <= presc_dec + vrc6_pkg::PRESCALE_RELOAD;
				else
					presc <= presc_dec;
			end

			if (cnt_clk)
			begin
				if (count == 8'hFF)
				begin
					count <= latch; // overflow reloads and fires
					irq   <= 1'b1;
				end
				else
					count <= count + 8'd1;
			end
		end
	end

	assign irq_st.latch = latch;
	assign irq_st.count = count;
	assign irq_st.ctrl  = ctrl;

endmodule

/* verilog/vrc6_map.sv */
`timescale 1ns/100ps

module vrc6_map
(
	input  vrc6_pkg::bank_regs_t regs,
	input  vrc6_pkg::cpu_bus_t   cpu,
	input  vrc6_pkg::ppu_addr_t  ppu_addr,
	input  logic                 ppu_oe,
	output vrc6_pkg::map_out_t   map_out
);

	logic [7:0] prg_bank;
	logic [7:0] chr_bank;

	// 16k window at 8000, 8k at C000, last 8k fixed
	always_comb
	begin
		case (cpu.addr[15:13])
			3'b110:  prg_bank = regs.prg1;
			3'b111:  prg_bank = 8'hFF;
			default: prg_bank = {regs.prg0[6:0], cpu.addr[13]};
		endcase
	end

	assign chr_bank = regs.chr[ppu_addr[12:10]];

	assign map_out.prg_addr = {prg_bank, cpu.addr[12:0]};
	assign map_out.chr_addr = {chr_bank, ppu_addr[9:0]};
	assign map_out.srm_addr = cpu.addr[12:0];

	always_comb
	begin
		case (regs.mir)
			2'd0:    map_out.ciram_a10 = ppu_addr[10]; // vertical
			2'd1:    map_out.ciram_a10 = ppu_addr[11]; // horizontal
			2'd2:    map_out.ciram_a10 = 1'b0;
			default: map_out.ciram_a10 = 1'b1;
		endcase
	end

	// nametables live at 2000..3FFF
	assign map_out.ciram_ce = ~ppu_addr[13];

	assign map_out.rom_ce = cpu.addr[15];
	assign map_out.ram_ce = (cpu.addr[15:13] == 3'b011); // 6000..7FFF
	assign map_out.ram_we = map_out.ram_ce & cpu.we;
	assign map_out.prg_oe = ~cpu.we;
	assign map_out.chr_oe = ~ppu_oe;

endmodule

/* verilog/vrc6_regs.sv */
`timescale 1ns/100ps

module vrc6_regs
(
	input  logic                 clk,
	input  logic                 map_rst,
	input  logic [7:0]           map_idx,
	input  vrc6_pkg::cpu_bus_t   cpu,
	input  vrc6_pkg::ss_bus_t    ss,
	input  vrc6_pkg::irq_state_t irq_st,
	output vrc6_pkg::bank_regs_t regs,
	output vrc6_pkg::irq_wr_t    irq_wr,
	output logic [7:0]           ss_rdat
);

	logic [1:0]  lo_plain; // A1:A0 order
	logic [1:0]  lo_swap;  // A0:A1 order
	logic [1:0]  reg_lo;
	logic [15:0] reg_addr;
	logic        bus_we;

	// A3:A2 take over the low lines when they are nonzero
	assign lo_plain = (cpu.addr[3:2] == 2'd0) ? cpu.addr[1:0] : cpu.addr[3:2];
	assign lo_swap  = (cpu.addr[3:2] == 2'd0) ? {cpu.addr[0], cpu.addr[1]} :
		{cpu.addr[2], cpu.addr[3]};

	always_comb
	begin
		case (map_idx)
			vrc6_pkg::MAP_VRC6A: reg_lo = lo_plain;
			vrc6_pkg::MAP_VRC6B: reg_lo = lo_swap;
			default:             reg_lo = lo_plain;
		endcase
	end

	assign reg_addr = {cpu.addr[15:12], 10'd0, reg_lo};
	assign bus_we   = cpu.we & ~ss.act; // save-state owns the registers

	// save-state first, then reset, then the cpu bus
	always_ff @(posedge clk)
	begin
		if (ss.act)
		begin
			if (ss.we)
			begin
				if (ss.addr[7:3] == vrc6_pkg::SS_CHR[7:3])
					regs.chr[ss.addr[2:0]] <= ss.wdat;
				if (ss.addr == vrc6_pkg::SS_PRG0)
					regs.prg0 <= ss.wdat;
				if (ss.addr == vrc6_pkg::SS_PRG1)
					regs.prg1 <= ss.wdat;
				if (ss.addr == vrc6_pkg::SS_MIR)
					regs.mir <= ss.wdat[1:0];
			end
		end
		else if (map_rst)
		begin
			regs.prg0 <= 8'd0;
			regs.prg1 <= 8'd1; // second 8k window starts one bank up
			regs.mir  <= 2'd0;
			regs.chr  <= '0;
		end
		else if (bus_we)
		begin
			// prg banks ignore the low lines entirely
			if (cpu.addr[15:12] == vrc6_pkg::REG_PRG0[15:12])
				regs.prg0 <= cpu.data;
			if (cpu.addr[15:12] == vrc6_pkg::REG_PRG1[15:12])
				regs.prg1 <= cpu.data;

			if (reg_addr == vrc6_pkg::REG_MIR)
				regs.mir <= cpu.data[3:2];

			if ({reg_addr[15:2], 2'b00} == vrc6_pkg::REG_CHR_LO)
				regs.chr[{1'b0, reg_addr[1:0]}] <= cpu.data;
			if ({reg_addr[15:2], 2'b00} == vrc6_pkg::REG_CHR_HI)
				regs.chr[{1'b1, reg_addr[1:0]}] <= cpu.data;
		end
	end

	// only F000..F002 reach the irq block
	assign irq_wr.we   = bus_we & ({reg_addr[15:2], 2'b00} == vrc6_pkg::REG_IRQ) &
		(reg_lo != 2'd3);
	assign irq_wr.sel  = reg_lo;
	assign irq_wr.data = cpu.data;

	always_comb
	begin
		case (ss.addr)
			vrc6_pkg::SS_PRG0:      ss_rdat = regs.prg0;
			vrc6_pkg::SS_PRG1:      ss_rdat = regs.prg1;
			vrc6_pkg::SS_MIR:       ss_rdat = {6'd0, regs.mir};
			vrc6_pkg::SS_IRQ_LATCH: ss_rdat = irq_st.latch;
			vrc6_pkg::SS_IRQ_COUNT: ss_rdat = irq_st.count;
			vrc6_pkg::SS_IRQ_CTRL:  ss_rdat = {5'd0, irq_st.ctrl};
			vrc6_pkg::SS_MAP_IDX:   ss_rdat = map_idx;
			default:
			begin
				if (ss.addr[7:3] == vrc6_pkg::SS_CHR[7:3])
					ss_rdat = regs.chr[ss.addr[2:0]];
				else
					ss_rdat = 8'hFF; // unmapped
			end
		endcase
	end

endmodule

/* verilog/vrc6_pkg.sv */
package vrc6_pkg;

	// one cpu bus cycle as seen on clk
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  data;
		logic        we;
	} cpu_bus_t;

	typedef logic [13:0] ppu_addr_t;

	typedef struct packed {
		logic [7:0]      prg0;
		logic [7:0]      prg1;
		logic [7:0][7:0] chr; // 1k chr banks
		logic [1:0]      mir;
	} bank_regs_t;

	typedef struct packed {
		logic       we;
		logic [1:0] sel; // latch, control, ack
		logic [7:0] data;
	} irq_wr_t;

	typedef struct packed {
		logic [7:0] latch;
		logic [7:0] count;
		logic [2:0] ctrl; // {m, e, a}
	} irq_state_t;

	typedef struct packed {
		logic       act;
		logic       we;
		logic [7:0] addr;
		logic [7:0] wdat;
	} ss_bus_t;

	typedef struct packed {
		logic [20:0] prg_addr;
		logic [17:0] chr_addr;
		logic [12:0] srm_addr;
		logic        ciram_a10;
		logic        ciram_ce;
		logic        rom_ce;
		logic        ram_ce;
		logic        ram_we;
		logic        prg_oe;
		logic        chr_oe;
	} map_out_t;

	// register bases on the cpu bus
	localparam logic [15:0] REG_PRG0   = 16'h8000;
	localparam logic [15:0] REG_MIR    = 16'hB003;
	localparam logic [15:0] REG_PRG1   = 16'hC000;
	localparam logic [15:0] REG_CHR_LO = 16'hD000;
	localparam logic [15:0] REG_CHR_HI = 16'hE000;
	localparam logic [15:0] REG_IRQ    = 16'hF000;

	localparam logic [7:0] SS_CHR       = 8'd0; // 0..7
	localparam logic [7:0] SS_PRG0      = 8'd16;
	localparam logic [7:0] SS_PRG1      = 8'd17;
	localparam logic [7:0] SS_MIR       = 8'd18;
	localparam logic [7:0] SS_IRQ_LATCH = 8'd32;
	localparam logic [7:0] SS_IRQ_COUNT = 8'd33;
	localparam logic [7:0] SS_IRQ_CTRL  = 8'd34;
	localparam logic [7:0] SS_MAP_IDX   = 8'd127;

	// irq register select and control bit positions
	localparam logic [1:0] IRQ_SEL_LATCH = 2'd0;
	localparam logic [1:0] IRQ_SEL_CTRL  = 2'd1;
	localparam logic [1:0] IRQ_SEL_ACK   = 2'd2;
	localparam int CTRL_A = 0;
	localparam int CTRL_E = 1;
	localparam int CTRL_M = 2;

	// one scanline is 341 ppu dots at three dots per cpu cycle
	localparam logic signed [9:0] PRESCALE_RELOAD = 10'sd341;
	localparam logic signed [9:0] PRESCALE_STEP   = 10'sd3;

	localparam logic [7:0] MAP_VRC6A = 8'd24;
	localparam logic [7:0] MAP_VRC6B = 8'd26;

endpackage
